/* sim/cache_vectors.txt */
// Columns: op bank addr wdata rdata hit (hex)
// op 1 read, 2 write, 3 invalidate, 4 counters (hits misses evictions in columns 2-4),
// op 5 end of test (test number in column 2), op 0 end of list
// Memory word a starts as {~a, a}

// Test 1: read miss, then hit
1 0 0010 00000000 ffef0010 0
1 0 0010 00000000 ffef0010 1
4 1 1 0 0 0
5 1 0 0 0 0

// Test 2: write hit, write miss, memory seen through the other bank
2 0 0010 a5a50001 00000000 1
1 0 0010 00000000 a5a50001 1
1 1 0010 00000000 a5a50001 0
2 0 0021 5a5a0002 00000000 0
1 0 0021 00000000 5a5a0002 0
4 3 4 0 0 0
5 2 0 0 0 0

// Test 3: LRU in weight set 5
1 0 0005 00000000 fffa0005 0
1 0 000d 00000000 fff2000d 0
1 0 0015 00000000 ffea0015 0
1 0 001d 00000000 ffe2001d 0
1 0 0005 00000000 fffa0005 1
1 0 0025 00000000 ffda0025 0
4 4 9 1 0 0
1 0 0005 00000000 fffa0005 1
1 0 0015 00000000 ffea0015 1
1 0 001d 00000000 ffe2001d 1
1 0 0025 00000000 ffda0025 1
1 0 000d 00000000 fff2000d 0
4 8 a 2 0 0
5 3 0 0 0 0

// Test 4: bank independence
1 0 0042 00000000 ffbd0042 0
1 1 0042 00000000 ffbd0042 0
2 0 0042 12345678 00000000 1
1 1 0042 00000000 ffbd0042 1
1 0 0042 00000000 12345678 1
4 b c 2 0 0
5 4 0 0 0 0

// Test 5: invalidate keeps counters
3 0 0 0 0 0
1 0 0010 00000000 a5a50001 0
1 1 0042 00000000 12345678 0
1 0 0015 00000000 ffea0015 0
1 1 0010 00000000 a5a50001 0
1 0 0010 00000000 a5a50001 1
4 c 10 2 0 0
5 5 0 0 0 0

0 0 0 0 0 0

/* build.f */
hw/cache_pkg.sv
hw/cache_bank.sv
hw/cache_ctrl.sv
hw/perf_counters.sv
hw/tpu_cache.sv
sim/tpu_cache_sva.sv
sim/tb_tpu_cache.sv

/* Makefile */
# Verilator build and run for the TPU cache testbench

VERILATOR ?= verilator
TOP       ?= tb_tpu_cache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log, not from the simulator exit code
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_tpu_cache.sv */
/*
 * TPU cache testbench
 * Vector-driven reads, writes and invalidates against a memory model
 */
module tb_tpu_cache;
    import cache_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int VEC_WORDS       = 512;
    localparam int WATCHDOG_CYCLES = 50;

    // One vector line, six hex columns
    typedef struct packed {
        logic [31:0] op;
        logic [31:0] bank;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] hit;
    } vec_line_t;

    logic      clk;
    logic      rst_n;
    addr_t     cpu_addr;
    logic      cpu_read;
    logic      cpu_write;
    data_t     cpu_wdata;
    bank_sel_t cpu_bank;
    data_t     cpu_rdata;
    logic      cpu_ready;
    logic      cpu_hit;
    addr_t     mem_addr;
    logic      mem_read;
    logic      mem_write;
    data_t     mem_wdata;
    data_t     mem_rdata;
    logic      mem_ready;
    logic      cache_invalidate;
    logic      cache_ready;
    count_t    hit_count;
    count_t    miss_count;
    count_t    eviction_count;

    data_t       mem_model [65536];
    logic [31:0] vec_mem [VEC_WORDS];
    logic [31:0] lcg_state = 32'hdd53;
    int          num_lines;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_errors_start;

    tpu_cache #(
        .WEIGHT_SETS (8),
        .ACT_SETS    (4),
        .WAYS        (4)
    ) u_tpu_cache (
        .clk              (clk),
        .rst_n            (rst_n),
        .cpu_addr         (cpu_addr),
        .cpu_read         (cpu_read),
        .cpu_write        (cpu_write),
        .cpu_wdata        (cpu_wdata),
        .cpu_bank         (cpu_bank),
        .cpu_rdata        (cpu_rdata),
        .cpu_ready        (cpu_ready),
        .cpu_hit          (cpu_hit),
        .mem_addr         (mem_addr),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .mem_ready        (mem_ready),
        .cache_invalidate (cache_invalidate),
        .cache_ready      (cache_ready),
        .hit_count        (hit_count),
        .miss_count       (miss_count),
        .eviction_count   (eviction_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory wait states, 0 to 3 cycles
    function automatic logic [1:0] next_wait();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[17:16];
    endfunction

    function automatic vec_line_t load_line(logic [8:0] base);
        vec_line_t v;
        v.op    = vec_mem[base];
        v.bank  = vec_mem[base + 9'd1];
        v.addr  = vec_mem[base + 9'd2];
        v.wdata = vec_mem[base + 9'd3];
        v.rdata = vec_mem[base + 9'd4];
        v.hit   = vec_mem[base + 9'd5];
        return v;
    endfunction

    task automatic access(input vec_line_t v, input logic is_write);
        data_t got_rdata;
        logic  got_hit;
        addr_t addr;
        addr = v.addr[ADDR_WIDTH-1:0];
        @(posedge clk);
        #1;
        cpu_addr  = addr;
        cpu_wdata = v.wdata;
        cpu_bank  = bank_sel_t'(v.bank[0]);
        cpu_read  = !is_write;
        cpu_write = is_write;
        do @(negedge clk); while (!cpu_ready);
        got_rdata = cpu_rdata;
        got_hit   = cpu_hit;
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
        assert (got_hit == v.hit[0]) else begin
            $display("FAILED %0t: %s bank %0d addr %h cpu_hit %0b, expected %0b", $time,
                     is_write ? "write" : "read", v.bank[0], addr, got_hit, v.hit[0]);
            errors++;
        end
        if (is_write) begin
            assert (mem_model[addr] == v.wdata) else begin
                $display("FAILED %0t: write addr %h left memory at %h, expected %h", $time,
                         addr, mem_model[addr], v.wdata);
                errors++;
            end
        end else begin
            assert (got_rdata == v.rdata) else begin
                $display("FAILED %0t: read bank %0d addr %h rdata %h, expected %h", $time,
                         v.bank[0], addr, got_rdata, v.rdata);
                errors++;
            end
        end
    endtask

    task automatic pulse_invalidate();
        @(negedge clk);
        assert (cache_ready) else begin
            $display("FAILED %0t: cache_ready low before invalidate", $time);
            errors++;
        end
        @(posedge clk);
        #1 cache_invalidate = 1'b1;
        @(posedge clk);
        #1 cache_invalidate = 1'b0;
        @(negedge clk);
        assert (!cache_ready) else begin
            $display("FAILED %0t: cache_ready high during invalidate", $time);
            errors++;
        end
        @(negedge clk);
        assert (cache_ready) else begin
            $display("FAILED %0t: cache_ready still low after invalidate", $time);
            errors++;
        end
    endtask

    task automatic check_counters(input vec_line_t v);
        @(negedge clk);
        assert (hit_count == v.bank) else begin
            $display("FAILED %0t: hit_count %0d, expected %0d", $time, hit_count, v.bank);
            errors++;
        end
        assert (miss_count == v.addr) else begin
            $display("FAILED %0t: miss_count %0d, expected %0d", $time, miss_count, v.addr);
            errors++;
        end
        assert (eviction_count == v.wdata) else begin
            $display("FAILED %0t: eviction_count %0d, expected %0d", $time,
                     eviction_count, v.wdata);
            errors++;
        end
    endtask

    task automatic end_test(input logic [31:0] num);
        int n_err;
        n_err = errors - test_errors_start;
        tests_run++;
        if (n_err == 0) begin
            $display("Test %0d: pass", num);
        end else begin
            tests_failed++;
            $display("Test %0d: fail, %0d errors", num, n_err);
        end
        test_errors_start = errors;
    endtask

    task automatic run_line(input vec_line_t v, input int n);
        case (v.op)
            32'd1:   access(v, 1'b0);
            32'd2:   access(v, 1'b1);
            32'd3:   pulse_invalidate();
            32'd4:   check_counters(v);
            32'd5:   end_test(v.bank);
            default: begin
                $display("Unknown opcode %0h on vector line %0d", v.op, n);
                errors++;
            end
        endcase
    endtask

    // Memory model, mem_ready after a random number of wait cycles
    initial begin
        addr_t      a;
        logic [1:0] wait_left;
        logic       busy;
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        wait_left = '0;
        a         = '0;
        do begin
            mem_model[a] = {~a, a};
            a = a + 1'b1;
        end while (a != '0);
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (mem_read || mem_write) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = next_wait();
                end
                if (wait_left == 2'd0) begin
                    mem_ready = 1'b1;
                    if (mem_read) begin
                        mem_rdata = mem_model[mem_addr];
                    end else begin
                        mem_model[mem_addr] = mem_wdata;
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    initial begin
        vec_line_t  v;
        logic [8:0] ptr;
        clk               = 1'b0;
        rst_n             = 1'b0;
        cpu_addr          = '0;
        cpu_read          = 1'b0;
        cpu_write         = 1'b0;
        cpu_wdata         = '0;
        cpu_bank          = BANK_WEIGHT;
        cache_invalidate  = 1'b0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_errors_start = 0;
        num_lines         = 0;
        ptr               = '0;
        do begin
            vec_mem[ptr] = '0;
            ptr = ptr + 9'd1;
        end while (ptr != '0);
        $readmemh("sim/cache_vectors.txt", vec_mem);
        // Opcode 0 ends the vector list
        while (num_lines < VEC_WORDS / 6 && vec_mem[ptr] != 32'd0) begin
            num_lines++;
            ptr = ptr + 9'd6;
        end
        if (num_lines == 0) begin
            $display("No vectors found in sim/cache_vectors.txt");
            errors++;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        ptr = '0;
        for (int n = 0; n < num_lines; n++) begin
            v = load_line(ptr);
            run_line(v, n);
            ptr = ptr + 9'd6;
        end
        $display("Tests run: %0d, tests failed: %0d, check failures: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog scaled by the number of vector lines
    initial begin
        wait (num_lines > 0);
        #(num_lines * WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: vectors did not finish within %0d cycles",
                 num_lines * WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/tpu_cache_sva.sv */
/*
 * Protocol assertions for the TPU cache top level
 */
module tpu_cache_sva (
    input logic clk,
    input logic rst_n,
    input logic cpu_ready,
    input logic cpu_hit,
    input logic mem_read,
    input logic mem_write,
    input logic mem_ready
);

    // Ready is a single-cycle strobe
    ready_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) cpu_ready |=> !cpu_ready
    ) else $error("cpu_ready held for more than one cycle");

    mem_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write high together");

    hit_with_ready: assert property (
        @(posedge clk) disable iff (!rst_n) cpu_hit |-> cpu_ready
    ) else $error("cpu_hit high without cpu_ready");

    // Read strobe held until memory answers
    read_held: assert property (
        @(posedge clk) disable iff (!rst_n) (mem_read && !mem_ready) |=> mem_read
    ) else $error("mem_read dropped before mem_ready");

endmodule

bind tpu_cache tpu_cache_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_ready (cpu_ready),
    .cpu_hit   (cpu_hit),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_ready (mem_ready)
);

/* hw/tpu_cache.sv */
/*
 * TPU on-chip cache top level
 * Write-through controller with weight and activation banks
 */
module tpu_cache #(
    parameter int WEIGHT_SETS = 8,
    parameter int ACT_SETS    = 4,
    parameter int WAYS        = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::addr_t     cpu_addr,
    input  logic                 cpu_read,
    input  logic                 cpu_write,
    input  cache_pkg::data_t     cpu_wdata,
    input  cache_pkg::bank_sel_t cpu_bank,
    output cache_pkg::data_t     cpu_rdata,
    output logic                 cpu_ready,
    output logic                 cpu_hit,
    output cache_pkg::addr_t     mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output cache_pkg::data_t     mem_wdata,
    input  cache_pkg::data_t     mem_rdata,
    input  logic                 mem_ready,
    input  logic                 cache_invalidate,
    output logic                 cache_ready,
    output cache_pkg::count_t    hit_count,
    output cache_pkg::count_t    miss_count,
    output cache_pkg::count_t    eviction_count
);
    import cache_pkg::*;

    cache_req_t   req;
    bank_status_t weight_status;
    bank_status_t act_status;
    data_t        fill_data;
    logic         weight_touch;
    logic         weight_fill;
    logic         act_touch;
    logic         act_fill;
    logic         invalidate;
    logic         hit_evt;
    logic         miss_evt;
    logic         evict_evt;

    cache_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .cpu_addr         (cpu_addr),
        .cpu_read         (cpu_read),
        .cpu_write        (cpu_write),
        .cpu_wdata        (cpu_wdata),
        .cpu_bank         (cpu_bank),
        .cache_invalidate (cache_invalidate),
        .weight_status    (weight_status),
        .act_status       (act_status),
        .mem_rdata        (mem_rdata),
        .mem_ready        (mem_ready),
        .req              (req),
        .weight_touch     (weight_touch),
        .weight_fill      (weight_fill),
        .act_touch        (act_touch),
        .act_fill         (act_fill),
        .invalidate       (invalidate),
        .fill_data        (fill_data),
        .cpu_rdata        (cpu_rdata),
        .cpu_ready        (cpu_ready),
        .cpu_hit          (cpu_hit),
        .mem_addr         (mem_addr),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_wdata        (mem_wdata),
        .cache_ready      (cache_ready),
        .hit_evt          (hit_evt),
        .miss_evt         (miss_evt),
        .evict_evt        (evict_evt)
    );

    cache_bank #(
        .SETS (WEIGHT_SETS),
        .WAYS (WAYS)
    ) u_weight_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .touch      (weight_touch),
        .fill       (weight_fill),
        .invalidate (invalidate),
        .fill_data  (fill_data),
        .status     (weight_status)
    );

    cache_bank #(
        .SETS (ACT_SETS),
        .WAYS (WAYS)
    ) u_act_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .touch      (act_touch),
        .fill       (act_fill),
        .invalidate (invalidate),
        .fill_data  (fill_data),
        .status     (act_status)
    );

    perf_counters u_perf (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_evt        (hit_evt),
        .miss_evt       (miss_evt),
        .evict_evt      (evict_evt),
        .hit_count      (hit_count),
        .miss_count     (miss_count),
        .eviction_count (eviction_count)
    );

endmodule

/* hw/perf_counters.sv */
/*
 * Cache performance counters
 * Free-running hit, miss and eviction counts
 */
module perf_counters (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hit_evt,
    input  logic              miss_evt,
    input  logic              evict_evt,
    output cache_pkg::count_t hit_count,
    output cache_pkg::count_t miss_count,
    output cache_pkg::count_t eviction_count
);

    // Counters wrap, only reset clears them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_count      <= '0;
            miss_count     <= '0;
            eviction_count <= '0;
        end else begin
            if (hit_evt) begin
                hit_count <= hit_count + 1'b1;
            end
            if (miss_evt) begin
                miss_count <= miss_count + 1'b1;
            end
            if (evict_evt) begin
                eviction_count <= eviction_count + 1'b1;
            end
        end
    end

endmodule

/* hw/cache_ctrl.sv */
/*
 * Cache controller
 * One request at a time: lookup, memory read/fill, write-through, invalidate
 */
module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::addr_t        cpu_addr,
    input  logic                    cpu_read,
    input  logic                    cpu_write,
    input  cache_pkg::data_t        cpu_wdata,
    input  cache_pkg::bank_sel_t    cpu_bank,
    input  logic                    cache_invalidate,
    input  cache_pkg::bank_status_t weight_status,
    input  cache_pkg::bank_status_t act_status,
    input  cache_pkg::data_t        mem_rdata,
    input  logic                    mem_ready,
    output cache_pkg::cache_req_t   req,
    output logic                    weight_touch,
    output logic                    weight_fill,
    output logic                    act_touch,
    output logic                    act_fill,
    output logic                    invalidate,
    output cache_pkg::data_t        fill_data,
    output cache_pkg::data_t        cpu_rdata,
    output logic                    cpu_ready,
    output logic                    cpu_hit,
    output cache_pkg::addr_t        mem_addr,
    output logic                    mem_read,
    output logic                    mem_write,
    output cache_pkg::data_t        mem_wdata,
    output logic                    cache_ready,
    output logic                    hit_evt,
    output logic                    miss_evt,
    output logic                    evict_evt
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_READ,
        FILL,
        MEM_WRITE,
        INVALIDATE
    } state_t;

    state_t       state;
    state_t       next_state;
    bank_status_t sel_status;
    logic         accept;
    logic         hit_q;
    logic         do_touch;
    logic         do_fill;

    // Invalidate wins over a coinciding request
    assign accept     = (state == IDLE) && !cache_invalidate && (cpu_read || cpu_write);
    assign sel_status = (req.bank == BANK_ACTIVATION) ? act_status : weight_status;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            hit_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == LOOKUP) begin
                hit_q <= sel_status.hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{addr: cpu_addr, wdata: cpu_wdata, write: cpu_write, bank: cpu_bank};
        end
        if (state == MEM_READ && mem_ready) begin
            fill_data <= mem_rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cache_invalidate) begin
                    next_state = INVALIDATE;
                end else if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req.write) begin
                    next_state = MEM_WRITE;
                end else if (sel_status.hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = MEM_READ;
                end
            end
            MEM_READ:   next_state = mem_ready ? FILL : MEM_READ;
            // Writes finish through FILL too, without allocating
            MEM_WRITE:  next_state = mem_ready ? FILL : MEM_WRITE;
            FILL:       next_state = IDLE;
            INVALIDATE: next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    assign do_touch = (state == LOOKUP) && sel_status.hit;
    assign do_fill  = (state == FILL) && !req.write;

    assign weight_touch = do_touch && (req.bank == BANK_WEIGHT);
    assign act_touch    = do_touch && (req.bank == BANK_ACTIVATION);
    assign weight_fill  = do_fill && (req.bank == BANK_WEIGHT);
    assign act_fill     = do_fill && (req.bank == BANK_ACTIVATION);
    assign invalidate   = (state == INVALIDATE);

    assign cpu_ready = (do_touch && !req.write) || (state == FILL);
    assign cpu_hit   = (do_touch && !req.write) || ((state == FILL) && hit_q);
    assign cpu_rdata = (state == FILL) ? fill_data : sel_status.hit_data;

    assign mem_addr  = req.addr;
    assign mem_wdata = req.wdata;
    assign mem_read  = (state == MEM_READ);
    assign mem_write = (state == MEM_WRITE);

    assign cache_ready = (state == IDLE);
    assign hit_evt     = do_touch;
    assign miss_evt    = (state == LOOKUP) && !sel_status.hit;
    assign evict_evt   = do_fill && sel_status.victim_valid;

endmodule

/* hw/cache_bank.sv */
/*
 * Set-associative cache bank
 * Tag/valid/data/age storage with hit lookup, LRU victim choice and update
 */
module cache_bank #(
    parameter int SETS = 8,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::cache_req_t   req,
    input  logic                    touch,
    input  logic                    fill,
    input  logic                    invalidate,
    input  cache_pkg::data_t        fill_data,
    output cache_pkg::bank_status_t status
);
    import cache_pkg::*;

    localparam int SET_SHIFT = $clog2(SETS);
    localparam int IDX_BITS  = (SETS > 1) ? SET_SHIFT : 1;
    localparam int TAG_BITS  = ADDR_WIDTH - SET_SHIFT;
    localparam int WAY_BITS  = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [WAY_BITS-1:0] age_t;

    logic [WAYS-1:0] valid_mem [SETS];
    age_t            age_mem   [SETS][WAYS];
    tag_t            tag_mem   [SETS][WAYS];
    data_t           data_mem  [SETS][WAYS];

    idx_t idx;
    tag_t tag;
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic found_invalid;
    age_t max_age;
    way_t upd_way;

    // Mask keeps the index at zero for a single-set bank
    assign idx = IDX_BITS'(req.addr) & IDX_BITS'(SETS - 1);
    assign tag = TAG_BITS'(req.addr >> SET_SHIFT);

    // First valid way with a matching tag
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && valid_mem[idx][w] && tag_mem[idx][w] == tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // Victim: first invalid way, else oldest with lowest way on a tie
    always_comb begin
        victim_way    = '0;
        found_invalid = 1'b0;
        max_age       = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!found_invalid) begin
                if (!valid_mem[idx][w]) begin
                    victim_way    = way_t'(w);
                    found_invalid = 1'b1;
                end else if (age_mem[idx][w] > max_age) begin
                    victim_way = way_t'(w);
                    max_age    = age_mem[idx][w];
                end
            end
        end
    end

    assign upd_way = fill ? victim_way : hit_way;

    assign status.hit          = hit;
    assign status.hit_data     = data_mem[idx][hit_way];
    assign status.victim_valid = valid_mem[idx][victim_way];

    // Valid bits and LRU ages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    age_mem[s][w] <= '0;
                end
            end
        end else if (invalidate) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (touch || fill) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == upd_way) begin
                    age_mem[idx][w] <= '0;
                end else if (valid_mem[idx][w] && age_mem[idx][w] != '1) begin
                    age_mem[idx][w] <= age_mem[idx][w] + 1'b1;
                end
            end
            if (fill) begin
                valid_mem[idx][victim_way] <= 1'b1;
            end
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[idx][victim_way]  <= tag;
            data_mem[idx][victim_way] <= fill_data;
        end else if (touch && req.write) begin
            data_mem[idx][hit_way] <= req.wdata;
        end
    end

endmodule

/* hw/cache_pkg.sv */
/*
 * TPU cache shared definitions
 * Word and address widths, request and bank status types
 */
package cache_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 16;

    // Word addresses, one word per line
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Free-running performance counter
    typedef logic [31:0] count_t;

    typedef enum logic {
        BANK_WEIGHT     = 1'b0,
        BANK_ACTIVATION = 1'b1
    } bank_sel_t;

    // Request as captured by the controller
    typedef struct packed {
        addr_t     addr;
        data_t     wdata;
        logic      write;
        bank_sel_t bank;
    } cache_req_t;

    // Lookup result of one bank for the current request
    typedef struct packed {
        logic  hit;
        data_t hit_data;
        logic  victim_valid;
    } bank_status_t;

endpackage
